//--- rtl/quplsPkg.sv
// ==========================================================
// Shared types and encodings for the decode front end.
// Opcodes are a small fixed subset; any other value decodes as
// illegal. Field positions are fixed: op 6..0, rd 11..7,
// rs1 16..12, rs2 21..17, immediate 31..17 (overlaps rs2).
// ==========================================================
package quplsPkg;

	typedef logic [31:0] instruction_t;
	typedef logic [6:0] opcode_t;
	typedef logic [4:0] regIdx_t;
	typedef logic [31:0] immValue_t;
	typedef logic [14:0] immField_t;
	typedef logic [2:0] unitClass_t;

	// ==========================================================
	// Opcode encodings
	// ==========================================================
	localparam opcode_t OP_ADD   = 7'd2;
	localparam opcode_t OP_ADDI  = 7'd4;
	localparam opcode_t OP_MULI  = 7'd6;
	localparam opcode_t OP_DIVI  = 7'd7;
	localparam opcode_t OP_AND   = 7'd8;
	localparam opcode_t OP_CMPI  = 7'd11;
	localparam opcode_t OP_ANDI  = 7'd12;
	localparam opcode_t OP_ORI   = 7'd13;
	localparam opcode_t OP_EORI  = 7'd14;
	localparam opcode_t OP_SEQI  = 7'd16;
	localparam opcode_t OP_SLTI  = 7'd18;
	localparam opcode_t OP_SLTUI = 7'd19;
	localparam opcode_t OP_JSR   = 7'd32;
	localparam opcode_t OP_RTD   = 7'd34;
	localparam opcode_t OP_LDB   = 7'd64;
	localparam opcode_t OP_LDW   = 7'd66;
	localparam opcode_t OP_LDO   = 7'd70;
	localparam opcode_t OP_STB   = 7'd80;
	localparam opcode_t OP_STW   = 7'd81;
	localparam opcode_t OP_STO   = 7'd83;
	localparam opcode_t OP_NOP   = 7'd127;

	// Execution unit classes handed on to rename
	localparam unitClass_t UC_ALU     = 3'd0;
	localparam unitClass_t UC_MULDIV  = 3'd1;
	localparam unitClass_t UC_LOAD    = 3'd2;
	localparam unitClass_t UC_STORE   = 3'd3;
	localparam unitClass_t UC_BRANCH  = 3'd4;
	localparam unitClass_t UC_ILLEGAL = 3'd7;

	// Decoded op, 58 bits, first field in the most significant bits
	typedef struct packed {
		opcode_t opcode;
		regIdx_t rd;
		regIdx_t rs1;
		regIdx_t rs2;
		logic hasImm;
		immValue_t imm;
		unitClass_t unitClass;
	} decodedOp_t;

	// ==========================================================
	// Field extraction, the only place the bit layout is written
	// ==========================================================
	function automatic opcode_t fnOpcode(input instruction_t instr);
		return instr[6:0];
	endfunction

	function automatic regIdx_t fnRd(input instruction_t instr);
		return instr[11:7];
	endfunction

	function automatic regIdx_t fnRs1(input instruction_t instr);
		return instr[16:12];
	endfunction

	function automatic regIdx_t fnRs2(input instruction_t instr);
		return instr[21:17];
	endfunction

	function automatic immField_t fnImmField(input instruction_t instr);
		return instr[31:17];
	endfunction

endpackage

//--- rtl/decodeHasImm.sv
// ==========================================================
// Flags instructions that carry an immediate field.
// Purely combinational; unknown opcodes report no immediate.
// ==========================================================
module decodeHasImm
(
	input quplsPkg::instruction_t instr,
	output logic hasImm
);
	import quplsPkg::*;

	always_comb
	begin
		case (fnOpcode(instr))
		// ALU immediate forms
		OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI,
		OP_ANDI, OP_ORI, OP_EORI:
			hasImm = 1'b1;
		// Set on compare against an immediate
		OP_SEQI, OP_SLTI, OP_SLTUI:
			hasImm = 1'b1;
		// Branch target displacement or stack adjust
		OP_JSR, OP_RTD:
			hasImm = 1'b1;
		// Memory ops use the immediate as an address offset
		OP_LDB, OP_LDW, OP_LDO,
		OP_STB, OP_STW, OP_STO:
			hasImm = 1'b1;
		default:
			hasImm = 1'b0;
		endcase
	end

endmodule

//--- rtl/decodeOpClass.sv
// ==========================================================
// Selects the execution unit class for an instruction.
// Opcodes outside the supported subset map to UC_ILLEGAL,
// which is the only exception indication produced here.
// ==========================================================
module decodeOpClass
(
	input quplsPkg::instruction_t instr,
	output quplsPkg::unitClass_t unitClass
);
	import quplsPkg::*;

	always_comb
	begin
		case (fnOpcode(instr))
		// Long latency arithmetic
		OP_MULI, OP_DIVI:
			unitClass = UC_MULDIV;
		OP_LDB, OP_LDW, OP_LDO:
			unitClass = UC_LOAD;
		OP_STB, OP_STW, OP_STO:
			unitClass = UC_STORE;
		// Both change the program counter
		OP_JSR, OP_RTD:
			unitClass = UC_BRANCH;
		// Everything else that is known runs on an ALU, NOP included
		OP_NOP, OP_ADD, OP_AND,
		OP_ADDI, OP_CMPI,
		OP_ANDI, OP_ORI, OP_EORI,
		OP_SEQI, OP_SLTI, OP_SLTUI:
			unitClass = UC_ALU;
		default:
			unitClass = UC_ILLEGAL;
		endcase
	end

endmodule

//--- rtl/decodeImm.sv
// ==========================================================
// Forms the 32-bit immediate from the 15-bit field.
// The value is produced for every opcode, even those with no
// immediate; the decode stage zeroes it when not present.
// ==========================================================
module decodeImm
(
	input quplsPkg::instruction_t instr,
	output quplsPkg::immValue_t imm
);
	import quplsPkg::*;

	immField_t field;

	assign field = fnImmField(instr);

	always_comb
	begin
		case (fnOpcode(instr))
		// Logical ops treat the field as an unsigned mask
		OP_ANDI, OP_ORI, OP_EORI:
			imm = {17'd0, field};
		// Branch displacement counts instruction words, so scale to bytes
		OP_JSR:
			imm = {{15{field[14]}}, field, 2'b00};
		default:
			imm = {{17{field[14]}}, field};
		endcase
	end

endmodule

//--- rtl/decodeQueue.sv
// ==========================================================
// Instruction queue between fetch and decode.
// Writes are never refused; fetch must hold a credit for each
// word it sends. One credit is returned per entry popped.
// A written word is visible at the head one cycle later.
// ==========================================================
module decodeQueue #(
	parameter int unsigned QDEPTH = 4
)
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	input quplsPkg::instruction_t inInstr,
	input logic pop,
	output logic qValid,
	output quplsPkg::instruction_t qInstr,
	output logic creditOut
);
	import quplsPkg::*;

	localparam int unsigned PTRW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
	localparam int unsigned CNTW = $clog2(QDEPTH + 1);

	typedef logic [PTRW-1:0] qPtr_t;
	typedef logic [CNTW-1:0] qCount_t;

	instruction_t mem [QDEPTH];
	qPtr_t wrPtr;
	qPtr_t rdPtr;
	qCount_t count;

	// Pointer advance with wrap, so any depth works and not only powers of two
	function automatic qPtr_t fnNextPtr(input qPtr_t ptr);
		return (ptr == qPtr_t'(QDEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// ==========================================================
	// Control state
	// ==========================================================
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (inValid)
				wrPtr <= fnNextPtr(wrPtr);
			if (pop)
				rdPtr <= fnNextPtr(rdPtr);
			// Simultaneous push and pop leaves the fill level unchanged
			count <= count + qCount_t'(inValid) - qCount_t'(pop);
		end
	end

	// Storage array holds payload only
	always_ff @(posedge clk)
	begin
		if (inValid)
			mem[wrPtr] <= inInstr;
	end

	assign qValid = (count != '0);
	assign qInstr = mem[rdPtr];

	// Each removal frees exactly one entry for fetch
	assign creditOut = pop;

endmodule

//--- rtl/decodeStage.sv
// ==========================================================
// Decode stage with credit flow control toward rename.
// A credit is taken at pop time, the cycle before outValid.
// Rename may return a credit in the same cycle one is spent.
// Output is registered: pop in cycle N, outValid in N+1.
// ==========================================================
module decodeStage #(
	parameter int unsigned OUTCREDITS = 2
)
(
	input logic clk,
	input logic rstN,
	input logic qValid,
	input quplsPkg::instruction_t qInstr,
	output logic pop,
	input logic creditIn,
	output logic outValid,
	output quplsPkg::decodedOp_t outOp
);
	import quplsPkg::*;

	localparam int unsigned CRW = $clog2(OUTCREDITS + 1);

	typedef logic [CRW-1:0] credit_t;

	credit_t credits;
	logic hasImm;
	immValue_t imm;
	unitClass_t unitClass;
	decodedOp_t nextOp;

	decodeHasImm uHasImm (.instr(qInstr), .hasImm(hasImm));
	decodeOpClass uOpClass (.instr(qInstr), .unitClass(unitClass));
	decodeImm uImm (.instr(qInstr), .imm(imm));

	// Take the head word only when rename has room for it
	assign pop = qValid && (credits != '0);

	// ==========================================================
	// Downstream credit counter
	// ==========================================================
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			credits <= credit_t'(OUTCREDITS);
		else
			credits <= credits - credit_t'(pop) + credit_t'(creditIn);
	end

	// Assemble the op; the immediate is masked here, once, for all opcodes
	always_comb
	begin
		nextOp.opcode = fnOpcode(qInstr);
		nextOp.rd = fnRd(qInstr);
		nextOp.rs1 = fnRs1(qInstr);
		nextOp.rs2 = fnRs2(qInstr);
		nextOp.hasImm = hasImm;
		nextOp.imm = hasImm ? imm : '0;
		nextOp.unitClass = unitClass;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else
			outValid <= pop;
	end

	// Payload register, only meaningful while outValid is high
	always_ff @(posedge clk)
	begin
		if (pop)
			outOp <= nextOp;
	end

endmodule

//--- rtl/decodeTop.sv
// ==========================================================
// Decode front end top: instruction queue feeding the stage.
// Fetch starts with QDEPTH credits, the stage with OUTCREDITS
// toward rename. Latency from write to outValid is 2 cycles.
// ==========================================================
module decodeTop #(
	parameter int unsigned QDEPTH = 4,
	parameter int unsigned OUTCREDITS = 2
)
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	input quplsPkg::instruction_t inInstr,
	output logic creditOut,
	input logic creditIn,
	output logic outValid,
	output quplsPkg::decodedOp_t outOp
);
	import quplsPkg::*;

	// Queue head and handshake toward the stage
	logic qValid;
	logic pop;
	instruction_t qInstr;

	decodeQueue #(
		.QDEPTH(QDEPTH)
	) uQueue (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inInstr(inInstr),
		.pop(pop),
		.qValid(qValid),
		.qInstr(qInstr),
		.creditOut(creditOut)
	);

	decodeStage #(
		.OUTCREDITS(OUTCREDITS)
	) uStage (
		.clk(clk),
		.rstN(rstN),
		.qValid(qValid),
		.qInstr(qInstr),
		.pop(pop),
		.creditIn(creditIn),
		.outValid(outValid),
		.outOp(outOp)
	);

endmodule

//--- test/clockGen.sv
// ==========================================================
// Free-running testbench clock and power-on reset.
// rstN is released 1 time unit after the last reset edge.
// ==========================================================
module clockGen #(
	parameter int PERIOD = 8,
	parameter int RESETCYCLES = 3
)
(
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Hold reset over the first rising edges
	initial
	begin
		rstN = 1'b0;
		repeat (RESETCYCLES) @(posedge clk);
		#1;
		rstN = 1'b1;
	end

endmodule

//--- test/decodeTop_chk.sv
// ==========================================================
// Protocol assertions bound into every decodeTop instance.
// Queue fill and ops held by rename are tracked from the top
// level ports; rename must credit only ops it has received.
// ==========================================================
module decodeTop_chk #(
	parameter int unsigned QDEPTH = 4,
	parameter int unsigned OUTCREDITS = 2
)
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic creditOut,
	input logic creditIn,
	input logic outValid
);
	int fill;
	int heldOps;

	// Entries in the queue, and ops rename has not yet credited back
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			fill <= 0;
			heldOps <= 0;
		end
		else
		begin
			fill <= fill + int'(inValid) - int'(creditOut);
			heldOps <= heldOps + int'(outValid) - int'(creditIn);
		end
	end

	// A write into a full queue would overwrite an unread word
	assert property (@(posedge clk) disable iff (!rstN) inValid |-> fill < int'(QDEPTH))
		else $error("decode queue written while full");

	// Rename can hold at most OUTCREDITS ops at any time
	assert property (@(posedge clk) disable iff (!rstN)
		outValid |-> heldOps < int'(OUTCREDITS))
		else $error("outValid high with no downstream credit");

	assert property (@(posedge clk) !rstN |-> !outValid && !creditOut)
		else $error("outValid or creditOut high during reset");

endmodule

bind decodeTop decodeTop_chk #(
	.QDEPTH(QDEPTH),
	.OUTCREDITS(OUTCREDITS)
) uChk (
	.clk(clk),
	.rstN(rstN),
	.inValid(inValid),
	.creditOut(creditOut),
	.creditIn(creditIn),
	.outValid(outValid)
);

//--- test/decodeTb.sv
// ==========================================================
// Testbench for decodeTop acting as both fetch and rename.
// Pass 1 returns credits at once and checks 2-cycle latency.
// Pass 2 gates sends and credit returns from an LFSR.
// Expected ops come from a hand-built table, in send order.
// ==========================================================
module decodeTb;
	import quplsPkg::*;

	localparam int QDEPTH = 4;
	localparam int OUTCREDITS = 2;

	typedef struct packed {
		instruction_t instr;
		decodedOp_t exp;
	} row_t;

	logic clk;
	logic rstN;
	logic inValid;
	instruction_t inInstr;
	logic creditOut;
	logic creditIn;
	logic outValid;
	decodedOp_t outOp;

	row_t rows[$];
	decodedOp_t expQ[$];
	int sentQ[$];
	int cycle = 0;
	int cycleLimit = 1000;
	int fetchCredits = QDEPTH;
	int pending = 0;
	int sentCount = 0;
	int creditPulses = 0;
	int checks = 0;
	int errors = 0;
	logic randomCredits = 1'b0;
	logic prevCreditOut = 1'b0;
	logic [31:0] lfsr = 32'h709744e6;

	clockGen #(.PERIOD(8), .RESETCYCLES(3)) uClock (.clk(clk), .rstN(rstN));

	decodeTop #(
		.QDEPTH(QDEPTH),
		.OUTCREDITS(OUTCREDITS)
	) UUT (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inInstr(inInstr),
		.creditOut(creditOut),
		.creditIn(creditIn),
		.outValid(outValid),
		.outOp(outOp)
	);

	// Taps 32, 22, 2, 1 give a maximal length sequence
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBit(output logic b);
		lfsr = lfsrStep(lfsr);
		b = lfsr[0];
	endtask

	// rs2 overlaps the low immediate bits, so it follows from the field
	task automatic addRow(input opcode_t op, input logic [14:0] immF, input logic hasImmExp,
		input unitClass_t uc, input immValue_t immExp);
		row_t r;
		regIdx_t rd;
		regIdx_t rs1;
		rd = regIdx_t'(rows.size() + 1);
		rs1 = regIdx_t'(30 - rows.size());
		r.instr = {immF, rs1, rd, op};
		r.exp.opcode = op;
		r.exp.rd = rd;
		r.exp.rs1 = rs1;
		r.exp.rs2 = immF[4:0];
		r.exp.hasImm = hasImmExp;
		r.exp.imm = immExp;
		r.exp.unitClass = uc;
		rows.push_back(r);
	endtask

	// ==========================================================
	// Stimulus table with expected decode results
	// ==========================================================
	task automatic buildTable();
		addRow(OP_ADDI,  15'h7FF0, 1'b1, UC_ALU,     32'hFFFF_FFF0);
		addRow(OP_CMPI,  15'h4000, 1'b1, UC_ALU,     32'hFFFF_C000);
		addRow(OP_MULI,  15'h0005, 1'b1, UC_MULDIV,  32'h0000_0005);
		addRow(OP_DIVI,  15'h7FFF, 1'b1, UC_MULDIV,  32'hFFFF_FFFF);
		addRow(OP_ANDI,  15'h7FFF, 1'b1, UC_ALU,     32'h0000_7FFF);
		addRow(OP_ORI,   15'h4001, 1'b1, UC_ALU,     32'h0000_4001);
		addRow(OP_EORI,  15'h5555, 1'b1, UC_ALU,     32'h0000_5555);
		addRow(OP_SEQI,  15'h0010, 1'b1, UC_ALU,     32'h0000_0010);
		addRow(OP_SLTI,  15'h6000, 1'b1, UC_ALU,     32'hFFFF_E000);
		addRow(OP_SLTUI, 15'h0042, 1'b1, UC_ALU,     32'h0000_0042);
		addRow(OP_JSR,   15'h0010, 1'b1, UC_BRANCH,  32'h0000_0040);
		addRow(OP_JSR,   15'h7FFE, 1'b1, UC_BRANCH,  32'hFFFF_FFF8);
		addRow(OP_RTD,   15'h0020, 1'b1, UC_BRANCH,  32'h0000_0020);
		addRow(OP_LDB,   15'h7F00, 1'b1, UC_LOAD,    32'hFFFF_FF00);
		addRow(OP_LDW,   15'h0100, 1'b1, UC_LOAD,    32'h0000_0100);
		addRow(OP_LDO,   15'h0008, 1'b1, UC_LOAD,    32'h0000_0008);
		addRow(OP_STB,   15'h4444, 1'b1, UC_STORE,   32'hFFFF_C444);
		addRow(OP_STW,   15'h0004, 1'b1, UC_STORE,   32'h0000_0004);
		addRow(OP_STO,   15'h3FFF, 1'b1, UC_STORE,   32'h0000_3FFF);
		addRow(OP_ADD,   15'h0006, 1'b0, UC_ALU,     32'h0000_0000);
		addRow(OP_AND,   15'h000A, 1'b0, UC_ALU,     32'h0000_0000);
		addRow(OP_NOP,   15'h0000, 1'b0, UC_ALU,     32'h0000_0000);
		addRow(7'd1,     15'h7FFF, 1'b0, UC_ILLEGAL, 32'h0000_0000);
		addRow(7'd100,   15'h1234, 1'b0, UC_ILLEGAL, 32'h0000_0000);
	endtask

	task automatic checkCredit(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkOp(input decodedOp_t got, input decodedOp_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			if (got.opcode !== exp.opcode)
				$display("Mismatch outOp.opcode: got %h expected %h", got.opcode, exp.opcode);
			if (got.rd !== exp.rd)
				$display("Mismatch outOp.rd: got %h expected %h", got.rd, exp.rd);
			if (got.rs1 !== exp.rs1)
				$display("Mismatch outOp.rs1: got %h expected %h", got.rs1, exp.rs1);
			if (got.rs2 !== exp.rs2)
				$display("Mismatch outOp.rs2: got %h expected %h", got.rs2, exp.rs2);
			if (got.hasImm !== exp.hasImm)
				$display("Mismatch outOp.hasImm: got %h expected %h", got.hasImm, exp.hasImm);
			if (got.imm !== exp.imm)
				$display("Mismatch outOp.imm: got %h expected %h", got.imm, exp.imm);
			if (got.unitClass !== exp.unitClass)
				$display("Mismatch outOp.unitClass: got %h expected %h", got.unitClass,
					exp.unitClass);
		end
	endtask

	// Rename takes the op, compares it in order and counts it as held
	task automatic receiveOp();
		decodedOp_t exp;
		int sentAt;
		if (expQ.size() == 0)
		begin
			errors++;
			$display("outValid was high at cycle %0d with no op outstanding", cycle);
		end
		else
		begin
			exp = expQ.pop_front();
			sentAt = sentQ.pop_front();
			checkOp(outOp, exp);
			if (!randomCredits)
				checkCredit("latency", cycle - sentAt, 2);
			if (pending >= OUTCREDITS)
			begin
				errors++;
				$display("outValid was high with all %0d rename credits in use", OUTCREDITS);
			end
			pending++;
		end
	endtask

	// One clock with inputs driven just after the rising edge and outputs read at the falling edge
	task automatic runCycle(input int row, output logic sent);
		logic b;
		@(posedge clk);
		#1;
		sent = 1'b0;
		inValid = 1'b0;
		creditIn = 1'b0;
		if (row >= 0 && fetchCredits > 0)
		begin
			inValid = 1'b1;
			inInstr = rows[row].instr;
			expQ.push_back(rows[row].exp);
			sentQ.push_back(cycle);
			fetchCredits--;
			sentCount++;
			sent = 1'b1;
		end
		// At most one credit goes back per cycle while rename holds ops
		if (pending > 0)
		begin
			b = 1'b1;
			if (randomCredits)
				takeBit(b);
			if (b)
			begin
				creditIn = 1'b1;
				pending--;
			end
		end
		@(negedge clk);
		// A pop returns its fetch credit one cycle before the decoded op appears
		checkCredit("outValid one cycle after creditOut", int'(outValid), int'(prevCreditOut));
		prevCreditOut = creditOut;
		if (creditOut)
		begin
			fetchCredits++;
			creditPulses++;
		end
		if (outValid)
			receiveOp();
	endtask

	task automatic drain();
		logic sent;
		while (expQ.size() != 0 || pending != 0)
			runCycle(-1, sent);
	endtask

	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (cycle > cycleLimit)
		begin
			$display("Timeout after %0d cycles with %0d ops still expected", cycleLimit,
				expQ.size());
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ==========================================================
	// Test sequence
	// ==========================================================
	initial
	begin
		logic sent;
		logic b;
		int errBefore;
		inValid = 1'b0;
		inInstr = '0;
		creditIn = 1'b0;
		buildTable();
		cycleLimit = rows.size() * 20 + 100;

		// Outputs must stay quiet for the whole reset
		while (rstN !== 1'b1)
		begin
			@(negedge clk);
			if (rstN !== 1'b1)
				checkCredit("outValid or creditOut in reset", int'(outValid | creditOut), 0);
		end

		// Sends spaced two cycles apart so credits never run out
		errBefore = errors;
		randomCredits = 1'b0;
		foreach (rows[i])
		begin
			sent = 1'b0;
			while (!sent)
				runCycle(i, sent);
			runCycle(-1, sent);
		end
		drain();
		$display("Test decode and latency: %0d ops, %0d errors", rows.size(), errors - errBefore);

		// Random gaps on fetch and random credit returns from rename
		errBefore = errors;
		randomCredits = 1'b1;
		foreach (rows[i])
		begin
			sent = 1'b0;
			while (!sent)
			begin
				takeBit(b);
				runCycle(b ? i : -1, sent);
			end
		end
		drain();
		$display("Test back-pressure: %0d ops, %0d errors", rows.size(), errors - errBefore);

		errBefore = errors;
		checkCredit("creditOut pulses", creditPulses, sentCount);
		checkCredit("fetch credits", fetchCredits, QDEPTH);
		$display("Test credit conservation: %0d words, %0d errors", sentCount,
			errors - errBefore);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- project.f
rtl/quplsPkg.sv
rtl/decodeHasImm.sv
rtl/decodeOpClass.sv
rtl/decodeImm.sv
rtl/decodeQueue.sv
rtl/decodeStage.sv
rtl/decodeTop.sv
test/clockGen.sv
test/decodeTop_chk.sv
test/decodeTb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = decodeTb
FLIST = project.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -x "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
